/* common/cr16Pkg.sv */
`default_nettype none

package cr16Pkg;

	// operation kinds after decode
	typedef enum logic [3:0]
	{
		ADD,
		ADDI,
		SUB,
		SUBI,
		CMP,
		CMPI,
		AND,
		OR,
		XOR,
		MOV,
		MOVI,
		LSH,
		ILLEGAL
	} opcode_e;

	// which part of the status register an instruction touches
	typedef enum logic [1:0]
	{
		NONE,
		// carry and overflow
		ARITH,
		// low, zero and negative
		COMPARE
	} flagGroup_e;

	// primary opcodes, instr[15:12]
	localparam logic [3:0] priRegGroup = 4'b0000;
	localparam logic [3:0] priAddi = 4'b0101;
	localparam logic [3:0] priSubi = 4'b1001;
	localparam logic [3:0] priCmpi = 4'b1011;
	localparam logic [3:0] priMovi = 4'b1101;
	// shift group, needs the matching extended code
	localparam logic [3:0] priLsh = 4'b1000;

	// extended opcodes, instr[7:4]
	localparam logic [3:0] extAdd = 4'b0101;
	localparam logic [3:0] extSub = 4'b1001;
	localparam logic [3:0] extCmp = 4'b1011;
	localparam logic [3:0] extAnd = 4'b0001;
	localparam logic [3:0] extOr = 4'b0010;
	localparam logic [3:0] extXor = 4'b0011;
	localparam logic [3:0] extMov = 4'b1101;
	localparam logic [3:0] extLsh = 4'b0100;

	// processor status flags
	typedef struct packed
	{
		// carry out of add, no-borrow of subtract
		logic carry;
		// unsigned dest < src
		logic low;
		// signed overflow of add or subtract
		logic overflow;
		// dest == src
		logic zero;
		// signed dest < src
		logic negative;
	} flags_t;

	// everything the datapath needs from one instruction word
	typedef struct packed
	{
		opcode_e op;
		logic [3:0] rDest;
		logic [3:0] rSrc;
		// sign extended from instr[7:0]
		logic [15:0] imm;
		logic useImm;
		logic writesDest;
		flagGroup_e flagGroup;
	} decodedInstr_t;

	// what leaves the unit one cycle after the instruction
	typedef struct packed
	{
		logic [3:0] destReg;
		logic [15:0] data;
		logic written;
	} wbResult_t;

endpackage

`default_nettype wire

/* src/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import cr16Pkg::*;
(
	input wire logic [15:0] instr,
	output decodedInstr_t decoded,
	output logic illegal
);

	logic [3:0] primary;
	logic [3:0] extended;
	opcode_e op;

	// opcode fields
	assign primary = instr[15:12];
	assign extended = instr[7:4];

	// map primary and extended codes onto an operation
	always_comb
	begin
		op = ILLEGAL;
		case (primary)
			priRegGroup:
			begin
				// register-register group, operation lives in instr[7:4]
				case (extended)
					extAdd: op = ADD;
					extSub: op = SUB;
					extCmp: op = CMP;
					extAnd: op = AND;
					extOr: op = OR;
					extXor: op = XOR;
					extMov: op = MOV;
					default: op = ILLEGAL;
				endcase
			end
			priAddi: op = ADDI;
			priSubi: op = SUBI;
			priCmpi: op = CMPI;
			priMovi: op = MOVI;
			// only the logical shift of this group is kept
			priLsh: op = (extended == extLsh) ? LSH : ILLEGAL;
			default: op = ILLEGAL;
		endcase
	end

	// attributes that follow from the operation
	always_comb
	begin
		decoded.op = op;
		decoded.rDest = instr[11:8];
		decoded.rSrc = instr[3:0];
		decoded.imm = {{8{instr[7]}}, instr[7:0]};
		decoded.useImm = op inside {ADDI, SUBI, CMPI, MOVI};
		// compares and unknown words leave the register file alone
		decoded.writesDest = !(op inside {CMP, CMPI, ILLEGAL});
		case (op)
			ADD, ADDI, SUB, SUBI: decoded.flagGroup = ARITH;
			CMP, CMPI: decoded.flagGroup = COMPARE;
			default: decoded.flagGroup = NONE;
		endcase
	end

	assign illegal = (op == ILLEGAL);

endmodule

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic [3:0] readAddrA,
	input wire logic [3:0] readAddrB,
	output logic [15:0] readDataA,
	output logic [15:0] readDataB,
	input wire logic writeEn,
	input wire logic [3:0] writeAddr,
	input wire logic [15:0] writeData
);

	// sixteen general purpose registers
	logic [15:0] regs [16];

	// port A, destination operand
	assign readDataA = regs[readAddrA];
	// port B, source operand
	assign readDataB = regs[readAddrB];

	// single write port, committed at the edge
	// next instruction already sees the new value
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			// architectural state starts at zero
			for (int i = 0; i < 16; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEn)
		begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

`default_nettype wire

/* alu/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import cr16Pkg::*;
(
	input wire decodedInstr_t decoded,
	input wire logic [15:0] operandA,
	input wire logic [15:0] operandB,
	output logic [15:0] value,
	output flags_t flagsOut
);

	// second operand after the immediate mux
	logic [15:0] srcOperand;
	// 17 bits so the carry falls out of the top
	logic [16:0] sum;
	logic [16:0] diff;
	logic [3:0] shiftAmount;
	logic shiftRight;
	logic isSubtract;
	logic addOverflow;
	logic subOverflow;

	assign srcOperand = decoded.useImm ? decoded.imm : operandB;

	// dest + src
	assign sum = {1'b0, operandA} + {1'b0, srcOperand};
	// dest - src as dest + ~src + 1
	// top bit is the no-borrow
	assign diff = {1'b0, operandA} + {1'b0, ~srcOperand} + 17'd1;

	// shift count in src[3:0] and direction in src[4]
	assign shiftAmount = srcOperand[3:0];
	assign shiftRight = srcOperand[4];

	assign isSubtract = decoded.op inside {SUB, SUBI, CMP, CMPI};

	// equal signs in that give a different sign out
	assign addOverflow = (operandA[15] == srcOperand[15]) && (sum[15] != operandA[15]);
	// differing signs in that leave the result unlike dest
	assign subOverflow = (operandA[15] != srcOperand[15]) && (diff[15] != operandA[15]);

	// result select
	always_comb
	begin
		case (decoded.op)
			ADD, ADDI: value = sum[15:0];
			// compare also hands out the difference
			SUB, SUBI, CMP, CMPI: value = diff[15:0];
			AND: value = operandA & srcOperand;
			OR: value = operandA | srcOperand;
			XOR: value = operandA ^ srcOperand;
			MOV, MOVI: value = srcOperand;
			LSH:
			begin
				// logical shift with zeros shifted in on both sides
				if (shiftRight)
				begin
					value = operandA >> shiftAmount;
				end
				else
				begin
					value = operandA << shiftAmount;
				end
			end
			default: value = '0;
		endcase
	end

	// flag candidates for writeback to pick from
	always_comb
	begin
		if (isSubtract)
		begin
			flagsOut.carry = diff[16];
			flagsOut.overflow = subOverflow;
		end
		else
		begin
			flagsOut.carry = sum[16];
			flagsOut.overflow = addOverflow;
		end
		// comparison of dest against src
		flagsOut.low = operandA < srcOperand;
		flagsOut.zero = operandA == srcOperand;
		flagsOut.negative = $signed(operandA) < $signed(srcOperand);
	end

endmodule

`default_nettype wire

/* src/writebackStage.sv */
`timescale 1ns/1ps
`default_nettype none

module writebackStage import cr16Pkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic instrValid,
	input wire logic illegal,
	input wire decodedInstr_t decoded,
	input wire logic [15:0] aluValue,
	input wire flags_t aluFlags,
	output logic writeEn,
	output logic [3:0] writeAddr,
	output logic [15:0] writeData,
	output logic resultValid,
	output wbResult_t result,
	output flags_t flags,
	output logic illegalPulse
);

	// a legal instruction is present this cycle
	logic accept;

	assign accept = instrValid && !illegal;

	// register file write on the same edge as the flag update
	assign writeEn = accept && decoded.writesDest;
	assign writeAddr = decoded.rDest;
	assign writeData = aluValue;

	// pulses and the held status flags
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			resultValid <= 1'b0;
			illegalPulse <= 1'b0;
			flags <= '0;
		end
		else
		begin
			resultValid <= accept;
			illegalPulse <= instrValid && illegal;
			if (accept)
			begin
				// merge only the group the instruction owns
				case (decoded.flagGroup)
					ARITH:
					begin
						flags.carry <= aluFlags.carry;
						flags.overflow <= aluFlags.overflow;
					end
					COMPARE:
					begin
						flags.low <= aluFlags.low;
						flags.zero <= aluFlags.zero;
						flags.negative <= aluFlags.negative;
					end
					default:
					begin
						flags <= flags;
					end
				endcase
			end
		end
	end

	// reported value is only meaningful while resultValid is high
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			result.destReg <= decoded.rDest;
			// compares still report the difference
			result.data <= aluValue;
			result.written <= decoded.writesDest;
		end
	end

endmodule

`default_nettype wire

/* src/cr16Datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cr16Datapath import cr16Pkg::*;
(
	input wire logic clk,
	input wire logic rstN,
	input wire logic instrValid,
	input wire logic [15:0] instr,
	output logic resultValid,
	output wbResult_t result,
	output flags_t flags,
	output logic illegal
);

	// decode outputs
	decodedInstr_t decoded;
	logic decodeIllegal;

	// register reads, A is dest and B is src
	logic [15:0] readDataA;
	logic [15:0] readDataB;

	// alu outputs
	logic [15:0] aluValue;
	flags_t aluFlags;

	// write port driven by writeback
	logic writeEn;
	logic [3:0] writeAddr;
	logic [15:0] writeData;

	instrDecoder u_instrDecoder
	(
		.instr(instr),
		.decoded(decoded),
		.illegal(decodeIllegal)
	);

	registerFile u_registerFile
	(
		.clk(clk),
		.rstN(rstN),
		.readAddrA(decoded.rDest),
		.readAddrB(decoded.rSrc),
		.readDataA(readDataA),
		.readDataB(readDataB),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(writeData)
	);

	alu u_alu
	(
		.decoded(decoded),
		.operandA(readDataA),
		.operandB(readDataB),
		.value(aluValue),
		.flagsOut(aluFlags)
	);

	// commit point, one cycle to the outputs
	writebackStage u_writebackStage
	(
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.illegal(decodeIllegal),
		.decoded(decoded),
		.aluValue(aluValue),
		.aluFlags(aluFlags),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.resultValid(resultValid),
		.result(result),
		.flags(flags),
		.illegalPulse(illegal)
	);

endmodule

`default_nettype wire

/* verification/cr16DatapathTb.sv */
`timescale 1ns/1ps
`default_nettype none

module cr16DatapathTb import cr16Pkg::*;
();

	logic clk;
	logic rstN;
	logic instrValid;
	logic [15:0] instr;
	logic resultValid;
	wbResult_t result;
	flags_t flags;
	logic illegal;

	int seed = 48611;
	// comparator mismatches and failures seen by the stimulus
	int errorCount = 0;
	int failCount = 0;

	// architectural state as predicted
	logic [15:0] modelRegs [16];
	flags_t modelFlags;
	// expectation for the outputs one cycle after an instruction
	wbResult_t expRes;
	flags_t expFlags;
	logic expValid;
	logic expIllegal;
	logic modelReady = 1'b0;

	// random instruction templates
	// {primary, extended} for register forms and primary only for immediates
	logic [7:0] regForms [8];
	logic [3:0] immForms [4];

	cr16Datapath u_cr16Datapath
	(
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.resultValid(resultValid),
		.result(result),
		.flags(flags),
		.illegal(illegal)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// operation kind straight from the encoding table
	function automatic opcode_e decodeKind(input logic [15:0] word);
		case (word[15:12])
			4'b0000:
			begin
				case (word[7:4])
					4'b0101: return ADD;
					4'b1001: return SUB;
					4'b1011: return CMP;
					4'b0001: return AND;
					4'b0010: return OR;
					4'b0011: return XOR;
					4'b1101: return MOV;
					default: return ILLEGAL;
				endcase
			end
			4'b0101: return ADDI;
			4'b1001: return SUBI;
			4'b1011: return CMPI;
			4'b1101: return MOVI;
			4'b1000: return (word[7:4] == 4'b0100) ? LSH : ILLEGAL;
			default: return ILLEGAL;
		endcase
	endfunction

	// reference model that applies one word to modelRegs and modelFlags
	function automatic void predictInstr(input logic [15:0] word, output wbResult_t res,
		output flags_t flagsNext, output logic isIllegal);
		opcode_e op;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] v;
		logic [16:0] wide;
		int sWide;
		op = decodeKind(word);
		a = modelRegs[word[11:8]];
		// immediate forms use the sign extended low byte as source
		if (op inside {ADDI, SUBI, CMPI, MOVI})
			b = {{8{word[7]}}, word[7:0]};
		else
			b = modelRegs[word[3:0]];
		v = '0;
		case (op)
			ADD, ADDI:
			begin
				wide = {1'b0, a} + {1'b0, b};
				v = wide[15:0];
				modelFlags.carry = wide[16];
				// true signed sum outside the 16-bit range
				sWide = $signed(a) + $signed(b);
				modelFlags.overflow = (sWide > 32767) || (sWide < -32768);
			end
			SUB, SUBI:
			begin
				v = a - b;
				// carry means no borrow
				modelFlags.carry = (a >= b);
				sWide = $signed(a) - $signed(b);
				modelFlags.overflow = (sWide > 32767) || (sWide < -32768);
			end
			CMP, CMPI:
			begin
				v = a - b;
				modelFlags.low = (a < b);
				modelFlags.zero = (a == b);
				modelFlags.negative = ($signed(a) < $signed(b));
			end
			AND: v = a & b;
			OR: v = a | b;
			XOR: v = a ^ b;
			MOV, MOVI: v = b;
			// bit 4 picks the direction
			LSH: v = b[4] ? (a >> b[3:0]) : (a << b[3:0]);
			default: v = '0;
		endcase
		isIllegal = (op == ILLEGAL);
		res.destReg = word[11:8];
		res.data = v;
		res.written = !(op inside {CMP, CMPI, ILLEGAL});
		if (res.written)
			modelRegs[word[11:8]] = v;
		flagsNext = modelFlags;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expected,
		input logic [15:0] actual, inout int count);
		assert (actual === expected)
		else
		begin
			count++;
			$display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	function automatic logic [15:0] encReg(input logic [3:0] ext, input logic [3:0] rd,
		input logic [3:0] rs);
		return {priRegGroup, rd, ext, rs};
	endfunction

	function automatic logic [15:0] encImm(input logic [3:0] pri, input logic [3:0] rd,
		input logic [7:0] imm);
		return {pri, rd, imm};
	endfunction

	// model steps at the same edge the DUT commits
	always @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 16; i++)
				modelRegs[i] = '0;
			modelFlags = '0;
			expFlags = '0;
			expValid = 1'b0;
			expIllegal = 1'b0;
			modelReady = 1'b1;
		end
		else if (instrValid)
		begin
			predictInstr(instr, expRes, expFlags, expIllegal);
			expValid = !expIllegal;
		end
		else
		begin
			expValid = 1'b0;
			expIllegal = 1'b0;
		end
	end

	// registered outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (modelReady)
		begin
			checkValue("resultValid", {15'b0, expValid}, {15'b0, resultValid}, errorCount);
			checkValue("illegal", {15'b0, expIllegal}, {15'b0, illegal}, errorCount);
			checkValue("flags", {11'b0, expFlags}, {11'b0, flags}, errorCount);
			if (expValid)
			begin
				checkValue("result.destReg", {12'b0, expRes.destReg}, {12'b0, result.destReg},
					errorCount);
				checkValue("result.data", expRes.data, result.data, errorCount);
				checkValue("result.written", {15'b0, expRes.written}, {15'b0, result.written},
					errorCount);
			end
		end
	end

	task automatic sendInstr(input logic [15:0] word);
		@(negedge clk);
		instrValid = 1'b1;
		instr = word;
	endtask

	// instr is a don't care here so it carries noise
	task automatic idleCycles(input int n);
		int r;
		for (int i = 0; i < n; i++)
		begin
			@(negedge clk);
			r = $random(seed);
			instrValid = 1'b0;
			instr = r[15:0];
		end
	endtask

	// drop valid and wait for the pulse of the last instruction
	task automatic waitResult();
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clk);
			instrValid = 1'b0;
			cycles++;
		end
		while (!(resultValid || illegal) && cycles < 8);
		if (!(resultValid || illegal))
		begin
			failCount++;
			$display("No resultValid or illegal pulse within %0d cycles", cycles);
		end
	endtask

	// one compare and its flags
	// then a MOV to show the destination untouched
	task automatic compareCase(input logic [15:0] word, input logic [2:0] lowZeroNeg,
		input logic [15:0] destValue);
		sendInstr(word);
		waitResult();
		checkValue("flags low/zero/negative", {13'b0, lowZeroNeg},
			{13'b0, flags.low, flags.zero, flags.negative}, failCount);
		checkValue("result.written", 16'd0, {15'b0, result.written}, failCount);
		sendInstr(encReg(extMov, word[11:8], word[11:8]));
		waitResult();
		checkValue("result.data", destValue, result.data, failCount);
	endtask

	initial
	begin : watchdog
		for (int i = 0; i < 5000; i++)
			@(posedge clk);
		$display("Simulation timed out before the test sequence ended");
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		int r;
		int tries;
		logic [15:0] word;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		regForms = '{{priRegGroup, extAdd}, {priRegGroup, extSub}, {priRegGroup, extCmp},
			{priRegGroup, extAnd}, {priRegGroup, extOr}, {priRegGroup, extXor},
			{priRegGroup, extMov}, {priLsh, extLsh}};
		immForms = '{priAddi, priSubi, priCmpi, priMovi};
		repeat (3) @(negedge clk);
		rstN = 1'b1;
		idleCycles(2);

		// registers clear after reset
		for (int i = 0; i < 16; i++)
			sendInstr(encReg(extMov, 4'(i), 4'(i)));
		idleCycles(1);

		// fibonacci chain ending at 987 in r15
		sendInstr(encImm(priAddi, 4'd0, 8'd1));
		sendInstr(encImm(priAddi, 4'd1, 8'd1));
		for (int k = 0; k < 14; k++)
		begin
			sendInstr(encReg(extMov, 4'(k + 2), 4'(k)));
			sendInstr(encReg(extAdd, 4'(k + 2), 4'(k + 1)));
		end
		sendInstr(encReg(extMov, 4'd15, 4'd15));
		waitResult();
		checkValue("r15", 16'd987, result.data, failCount);

		// random legal traffic with a few gaps
		for (int n = 0; n < 300; n++)
		begin
			r = $random(seed);
			if (r[20])
				word = {immForms[r[9:8]], r[19:16], r[7:0]};
			else
				word = {regForms[r[10:8]][7:4], r[19:16], regForms[r[10:8]][3:0], r[3:0]};
			sendInstr(word);
			if (r[31:29] == 3'b000)
				idleCycles(1);
		end
		idleCycles(1);

		// equal, unsigned lower only and signed lower only pairs
		sendInstr(encImm(priMovi, 4'd1, 8'd5));
		sendInstr(encImm(priMovi, 4'd2, 8'd5));
		sendInstr(encImm(priMovi, 4'd3, 8'd3));
		sendInstr(encImm(priMovi, 4'd4, 8'hfe));
		compareCase(encReg(extCmp, 4'd1, 4'd2), 3'b010, 16'd5);
		compareCase(encReg(extCmp, 4'd1, 4'd4), 3'b100, 16'd5);
		compareCase(encReg(extCmp, 4'd4, 4'd1), 3'b001, 16'hfffe);
		compareCase(encImm(priCmpi, 4'd3, 8'd3), 3'b010, 16'd3);
		compareCase(encImm(priCmpi, 4'd3, 8'hff), 3'b100, 16'd3);

		// illegal words change nothing
		for (int n = 0; n < 20; n++)
		begin
			tries = 0;
			do
			begin
				r = $random(seed);
				word = r[15:0];
				tries++;
			end
			while (decodeKind(word) != ILLEGAL && tries < 100);
			sendInstr(word);
			waitResult();
			checkValue("illegal", 16'd1, {15'b0, illegal}, failCount);
		end
		for (int i = 0; i < 16; i++)
			sendInstr(encReg(extMov, 4'(i), 4'(i)));

		// dependent ops back to back and then a gap
		sendInstr(encImm(priMovi, 4'd5, 8'd3));
		sendInstr(encReg(extAdd, 4'd5, 4'd5));
		sendInstr(encReg(extAdd, 4'd5, 4'd5));
		// right by 2
		sendInstr(encImm(priMovi, 4'd6, 8'h12));
		sendInstr({priLsh, 4'd5, extLsh, 4'd6});
		sendInstr(encImm(priSubi, 4'd5, 8'd3));
		idleCycles(3);
		sendInstr(encReg(extMov, 4'd7, 4'd5));
		waitResult();
		checkValue("r5", 16'd0, result.data, failCount);
		idleCycles(2);

		$display("Done: %0d compare errors, %0d sequence errors", errorCount, failCount);
		if (errorCount == 0 && failCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* cr16Datapath.f */
common/cr16Pkg.sv
src/instrDecoder.sv
src/registerFile.sv
alu/alu.sv
src/writebackStage.sv
src/cr16Datapath.sv
verification/cr16DatapathTb.sv

/* build.sh */
#!/bin/sh
# compile and run the cr16Datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
simName=cr16DatapathSim

# build the simulation binary into obj_dir
verilator --binary --timing --assert \
	-f cr16Datapath.f \
	--top-module cr16DatapathTb \
	-o "$simName"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

# run, keep the output for the search below
./obj_dir/"$simName" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the fail message decides the outcome
if grep -q "Test FAILED" "$logFile"; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"
exit 0
